/* io_defines.svh */
// ####################
// Timing and width constants for the peripheral I/O block
// Include wherever a divider, counter or word width is needed
// ####################

`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// Gamepad scan timing, in clk_2x cycles
`define IO_PAD_POLL_CYCLES 2000
`define IO_PAD_CLK_DIV 4

// Buttons per pad
`define IO_PAD_BITS 12

// Sound-chip serial port timing, in clk_2x cycles
`define IO_YM_SHIFT_DIV 2
`define IO_YM_CLK_DIV 2

// Data byte, A0, chip select, write, clear and volume control
`define IO_YM_WORD_BITS 14

`endif

/* io_pkg.sv */
// ####################
// Types shared by the I/O block and its testbench
// Import with io_pkg::* in the module header
// ####################

`default_nettype none

package io_pkg;

    // Active-high buttons, b2 is the first bit out of the pad
    typedef struct packed {
        logic r;
        logic l;
        logic x;
        logic a;
        logic b1;
        logic b3;
        logic down;
        logic up;
        logic start;
        logic select;
        logic y;
        logic b2;
    } pad_buttons_t;

    // One sound-chip board word, shifted out MSB first
    typedef struct packed {
        logic       volume_clk;
        logic       volume_up_down;
        logic       ic_n;
        logic       wr_n;
        logic       cs_n;
        logic       a0;
        logic [7:0] data;
    } ym_word_t;

    typedef enum logic [2:0] {
        REG_LED    = 3'd0,
        REG_PAD1   = 3'd1,
        REG_PAD2   = 3'd2,
        REG_STATUS = 3'd3,
        REG_YM     = 3'd4
    } io_reg_e;

    typedef struct packed {
        logic        write;
        logic        read;
        io_reg_e     addr;
        logic [15:0] wdata;
    } io_bus_req_t;

    typedef struct packed {
        logic [7:0] pad_seq;
        logic [5:0] reserved;
        logic       overrun;
        logic       ym_busy;
    } io_status_t;

    typedef enum logic [1:0] {
        PAD_IDLE,
        PAD_LATCH,
        PAD_SHIFT
    } pad_state_e;

    typedef enum logic [1:0] {
        YM_IDLE,
        YM_SHIFT,
        YM_LOAD
    } ym_state_e;

endpackage

`default_nettype wire

/* gamepad_reader.sv */
// ####################
// Periodic scan of two serial gamepads on a shared latch and clock
// pad1 and pad2 update together with the one-cycle pad_done pulse
// ####################

`timescale 1ns/1ps
`default_nettype none

`include "io_defines.svh"

module gamepad_reader import io_pkg::*; (
    input  wire logic         clk_2x,
    input  wire logic         arst_n,
    input  wire logic [1:0]   pad_data,
    output logic              pad_latch,
    output logic              pad_clk,
    output pad_buttons_t      pad1,
    output pad_buttons_t      pad2,
    output logic              pad_done
);
    localparam int POLL_CYCLES = `IO_PAD_POLL_CYCLES;
    localparam int CLK_DIV = `IO_PAD_CLK_DIV;
    localparam int PAD_BITS = `IO_PAD_BITS;
    localparam int POLL_W = $clog2(POLL_CYCLES);
    localparam int DIV_W = $clog2(2 * CLK_DIV);
    localparam int BIT_W = $clog2(PAD_BITS);

    pad_state_e state;
    logic [POLL_W-1:0] poll_cnt;
    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic [PAD_BITS-1:0] sr1;
    logic [PAD_BITS-1:0] sr2;
    logic half_done;
    logic latch_done;
    logic sample;

    assign half_done = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign latch_done = (div_cnt == DIV_W'(2 * CLK_DIV - 1));

    // Sampled just before pad_clk rises, so the pad has not yet advanced
    assign sample = (state == PAD_SHIFT) && half_done && !pad_clk;

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            poll_cnt <= '0;
        end else if (poll_cnt == POLL_W'(POLL_CYCLES - 1)) begin
            poll_cnt <= '0;
        end else begin
            poll_cnt <= poll_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            state <= PAD_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            pad_latch <= 1'b0;
            pad_clk <= 1'b1;
            pad1 <= '0;
            pad2 <= '0;
            pad_done <= 1'b0;
        end else begin
            pad_done <= 1'b0;
            div_cnt <= div_cnt + 1'b1;

            case (state)
                PAD_IDLE: begin
                    div_cnt <= '0;
                    if (poll_cnt == '0) begin
                        pad_latch <= 1'b1;
                        state <= PAD_LATCH;
                    end
                end
                PAD_LATCH: begin
                    if (latch_done) begin
                        pad_latch <= 1'b0;
                        pad_clk <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state <= PAD_SHIFT;
                    end
                end
                PAD_SHIFT: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        if (!pad_clk) begin
                            pad_clk <= 1'b1;
                        end else if (bit_cnt == BIT_W'(PAD_BITS - 1)) begin
                            // Last high phase done, publish both pads at once
                            pad1 <= pad_buttons_t'(sr1);
                            pad2 <= pad_buttons_t'(sr2);
                            pad_done <= 1'b1;
                            state <= PAD_IDLE;
                        end else begin
                            pad_clk <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= PAD_IDLE;
                end
            endcase
        end
    end

    // Pad data is active low, first bit lands in the LSB after 12 shifts
    always_ff @(posedge clk_2x) begin
        if (sample) begin
            sr1 <= {~pad_data[0], sr1[PAD_BITS-1:1]};
            sr2 <= {~pad_data[1], sr2[PAD_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

/* ym_pmod_shifter.sv */
// ####################
// Serial link to the sound-chip board and its master clock
// Pulse ym_start with a word, wait for ym_busy to fall
// ####################

`timescale 1ns/1ps
`default_nettype none

`include "io_defines.svh"

module ym_pmod_shifter import io_pkg::*; (
    input  wire logic     clk_2x,
    input  wire logic     arst_n,
    input  wire logic     ym_start,
    input  wire ym_word_t ym_word,
    output logic          ym_busy,
    output logic          ym_pmod_clk,
    output logic          ym_pmod_shift_clk,
    output logic          ym_pmod_shift_out,
    output logic          ym_pmod_shift_load
);
    localparam int SHIFT_DIV = `IO_YM_SHIFT_DIV;
    localparam int CLK_DIV = `IO_YM_CLK_DIV;
    localparam int WORD_BITS = `IO_YM_WORD_BITS;
    localparam int SHIFT_W = (SHIFT_DIV > 1) ? $clog2(SHIFT_DIV) : 1;
    localparam int CLK_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int BIT_W = $clog2(WORD_BITS);

    ym_state_e state;
    logic [SHIFT_W-1:0] div_cnt;
    logic [CLK_W-1:0] clk_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic [WORD_BITS-2:0] word_sr;
    logic half_done;
    logic accept;
    logic next_bit;

    assign half_done = (div_cnt == SHIFT_W'(SHIFT_DIV - 1));
    assign accept = (state == YM_IDLE) && ym_start;

    // Advance on the falling edge of the shift clock, except after the last bit
    assign next_bit = (state == YM_SHIFT) && half_done && ym_pmod_shift_clk &&
                      (bit_cnt != BIT_W'(WORD_BITS - 1));

    assign ym_busy = (state != YM_IDLE);

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            state <= YM_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            ym_pmod_shift_clk <= 1'b0;
            ym_pmod_shift_out <= 1'b0;
            ym_pmod_shift_load <= 1'b0;
        end else begin
            div_cnt <= half_done ? '0 : div_cnt + 1'b1;

            case (state)
                YM_IDLE: begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    if (accept) begin
                        ym_pmod_shift_out <= ym_word[WORD_BITS-1];
                        state <= YM_SHIFT;
                    end
                end
                YM_SHIFT: begin
                    if (half_done) begin
                        if (!ym_pmod_shift_clk) begin
                            ym_pmod_shift_clk <= 1'b1;
                        end else if (next_bit) begin
                            ym_pmod_shift_clk <= 1'b0;
                            ym_pmod_shift_out <= word_sr[WORD_BITS-2];
                            bit_cnt <= bit_cnt + 1'b1;
                        end else begin
                            ym_pmod_shift_clk <= 1'b0;
                            ym_pmod_shift_load <= 1'b1;
                            state <= YM_LOAD;
                        end
                    end
                end
                YM_LOAD: begin
                    if (half_done) begin
                        ym_pmod_shift_load <= 1'b0;
                        ym_pmod_shift_out <= 1'b0;
                        state <= YM_IDLE;
                    end
                end
                default: begin
                    state <= YM_IDLE;
                end
            endcase
        end
    end

    // The MSB goes out straight from ym_word, only the rest is held here
    always_ff @(posedge clk_2x) begin
        if (accept) begin
            word_sr <= ym_word[WORD_BITS-2:0];
        end else if (next_bit) begin
            word_sr <= {word_sr[WORD_BITS-3:0], 1'b0};
        end
    end

    // Free-running master clock for the sound chip
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            clk_cnt <= '0;
            ym_pmod_clk <= 1'b0;
        end else if (clk_cnt == CLK_W'(CLK_DIV - 1)) begin
            clk_cnt <= '0;
            ym_pmod_clk <= ~ym_pmod_clk;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* io_regs.sv */
// ####################
// CPU register bus for LEDs, gamepads, status and sound-chip writes
// Write strobes act on the edge, read data follows one cycle later
// ####################

`timescale 1ns/1ps
`default_nettype none

`include "io_defines.svh"

module io_regs import io_pkg::*; (
    input  wire logic         clk_2x,
    input  wire logic         arst_n,
    input  wire io_bus_req_t  bus_req,
    input  wire pad_buttons_t pad1,
    input  wire pad_buttons_t pad2,
    input  wire logic         pad_done,
    input  wire logic         ym_busy,
    output logic [15:0]       rdata,
    output logic [7:0]        led,
    output logic              ym_start,
    output ym_word_t          ym_word
);
    localparam int PAD_PAD_W = 16 - `IO_PAD_BITS;
    localparam int WORD_BITS = `IO_YM_WORD_BITS;

    logic [7:0] pad_seq;
    logic overrun;
    logic wr_led;
    logic wr_status;
    logic wr_ym;
    logic ym_blocked;
    io_status_t status;
    logic [15:0] read_mux;

    assign wr_led = bus_req.write && (bus_req.addr == REG_LED);
    assign wr_status = bus_req.write && (bus_req.addr == REG_STATUS);
    assign wr_ym = bus_req.write && (bus_req.addr == REG_YM);

    // A start still in flight counts as busy, the shifter has not seen it yet
    assign ym_blocked = ym_busy || ym_start;

    always_comb begin
        status = '0;
        status.pad_seq = pad_seq;
        status.overrun = overrun;
        status.ym_busy = ym_busy;
    end

    always_comb begin
        case (bus_req.addr)
            REG_LED:    read_mux = {8'h00, led};
            REG_PAD1:   read_mux = {{PAD_PAD_W{1'b0}}, pad1};
            REG_PAD2:   read_mux = {{PAD_PAD_W{1'b0}}, pad2};
            REG_STATUS: read_mux = status;
            default:    read_mux = '0;
        endcase
    end

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (bus_req.read) begin
            rdata <= read_mux;
        end
    end

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;
        end else if (wr_led) begin
            led <= bus_req.wdata[7:0];
        end
    end

    // Counts completed gamepad scans, wraps at 8 bits
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            pad_seq <= '0;
        end else if (pad_done) begin
            pad_seq <= pad_seq + 1'b1;
        end
    end

    // Sticky until software writes the status register
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            overrun <= 1'b0;
        end else if (wr_status) begin
            overrun <= 1'b0;
        end else if (wr_ym && ym_blocked) begin
            overrun <= 1'b1;
        end
    end

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            ym_start <= 1'b0;
        end else begin
            ym_start <= wr_ym && !ym_blocked;
        end
    end

    always_ff @(posedge clk_2x) begin
        if (wr_ym && !ym_blocked) begin
            ym_word <= ym_word_t'(bus_req.wdata[WORD_BITS-1:0]);
        end
    end

endmodule

`default_nettype wire

/* io_subsystem.sv */
// ####################
// Peripheral I/O block top level
// Register bus, gamepad scanner and sound-chip serial port
// ####################

`timescale 1ns/1ps
`default_nettype none

module io_subsystem import io_pkg::*; (
    input  wire logic        clk_2x,
    input  wire logic        arst_n,
    input  wire io_bus_req_t bus_req,
    output logic [15:0]      rdata,
    output logic [7:0]       led,
    output logic             pad_latch,
    output logic             pad_clk,
    input  wire logic [1:0]  pad_data,
    output logic             ym_pmod_clk,
    output logic             ym_pmod_shift_clk,
    output logic             ym_pmod_shift_out,
    output logic             ym_pmod_shift_load
);
    pad_buttons_t pad1;
    pad_buttons_t pad2;
    logic pad_done;
    logic ym_start;
    logic ym_busy;
    ym_word_t ym_word;

    io_regs io_regs_i (
        .clk_2x   (clk_2x),
        .arst_n   (arst_n),
        .bus_req  (bus_req),
        .pad1     (pad1),
        .pad2     (pad2),
        .pad_done (pad_done),
        .ym_busy  (ym_busy),
        .rdata    (rdata),
        .led      (led),
        .ym_start (ym_start),
        .ym_word  (ym_word)
    );

    // Bit 0 of pad_data is player 1
    gamepad_reader gamepad_reader_i (
        .clk_2x    (clk_2x),
        .arst_n    (arst_n),
        .pad_data  (pad_data),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .pad1      (pad1),
        .pad2      (pad2),
        .pad_done  (pad_done)
    );

    ym_pmod_shifter ym_pmod_shifter_i (
        .clk_2x             (clk_2x),
        .arst_n             (arst_n),
        .ym_start           (ym_start),
        .ym_word            (ym_word),
        .ym_busy            (ym_busy),
        .ym_pmod_clk        (ym_pmod_clk),
        .ym_pmod_shift_clk  (ym_pmod_shift_clk),
        .ym_pmod_shift_out  (ym_pmod_shift_out),
        .ym_pmod_shift_load (ym_pmod_shift_load)
    );

endmodule

`default_nettype wire

/* mock_gamepad.sv */
// ####################
// Model of one serial gamepad with active-low data
// Loads the held buttons on the latch, shifts on each rising pad_clk
// ####################

`timescale 1ns/1ps
`default_nettype none

`include "io_defines.svh"

module mock_gamepad import io_pkg::*; (
    input  wire logic         arst_n,
    input  wire logic         pad_latch,
    input  wire logic         pad_clk,
    input  wire pad_buttons_t buttons,
    output logic              data
);
    localparam int PAD_BITS = `IO_PAD_BITS;

    logic [PAD_BITS-1:0] shift_reg;

    // b2 sits in the LSB and goes out first
    always @(posedge pad_clk or posedge pad_latch or negedge arst_n) begin
        if (!arst_n) begin
            shift_reg <= '0;
        end else if (pad_latch) begin
            shift_reg <= buttons;
        end else begin
            shift_reg <= {1'b0, shift_reg[PAD_BITS-1:1]};
        end
    end

    // A pressed button pulls the line low
    assign data = ~shift_reg[0];

endmodule

`default_nettype wire

/* io_subsystem_tb.sv */
// ####################
// Testbench for the peripheral I/O block
// Drives the register bus, models two gamepads and the sound-chip board
// ####################

`timescale 1ns/1ps
`default_nettype none

`include "io_defines.svh"

module io_subsystem_tb import io_pkg::*; ();
    localparam int YM_WORDS = 10;
    // Two scan periods per gamepad round, twenty sound-chip words, and slack
    localparam int TIMEOUT_CYCLES = 12 * `IO_PAD_POLL_CYCLES + 20 * 80 + 2000;
    localparam io_bus_req_t IDLE_REQ = '{write: 1'b0, read: 1'b0, addr: REG_LED,
                                         wdata: 16'h0000};

    logic clk_2x;
    logic arst_n;
    io_bus_req_t bus_req;
    logic [15:0] rdata;
    logic [7:0] led;
    logic pad_latch;
    logic pad_clk;
    wire [1:0] pad_data;
    logic ym_pmod_clk;
    logic ym_pmod_shift_clk;
    logic ym_pmod_shift_out;
    logic ym_pmod_shift_load;
    pad_buttons_t buttons1;
    pad_buttons_t buttons2;
    logic [`IO_YM_WORD_BITS-1:0] capture_sr;
    ym_word_t ym_last;
    int ym_count = 0;
    int cycle_count = 0;
    int error_count = 0;
    int check_count = 0;
    logic [31:0] rng_state;

    io_subsystem io_subsystem_i (
        .clk_2x             (clk_2x),
        .arst_n             (arst_n),
        .bus_req            (bus_req),
        .rdata              (rdata),
        .led                (led),
        .pad_latch          (pad_latch),
        .pad_clk            (pad_clk),
        .pad_data           (pad_data),
        .ym_pmod_clk        (ym_pmod_clk),
        .ym_pmod_shift_clk  (ym_pmod_shift_clk),
        .ym_pmod_shift_out  (ym_pmod_shift_out),
        .ym_pmod_shift_load (ym_pmod_shift_load)
    );

    mock_gamepad player1_pad (
        .arst_n    (arst_n),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .buttons   (buttons1),
        .data      (pad_data[0])
    );

    mock_gamepad player2_pad (
        .arst_n    (arst_n),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .buttons   (buttons2),
        .data      (pad_data[1])
    );

    initial begin
        clk_2x = 1'b0;
        forever begin
            #50 clk_2x = ~clk_2x;
        end
    end

    // Sound-chip board shift register and its output latch
    always @(posedge ym_pmod_shift_clk) begin
        capture_sr <= {capture_sr[`IO_YM_WORD_BITS-2:0], ym_pmod_shift_out};
    end

    always @(posedge ym_pmod_shift_load or negedge arst_n) begin
        if (!arst_n) begin
            ym_count <= 0;
        end else begin
            ym_count <= ym_count + 1;
            ym_last <= ym_word_t'(capture_sr);
        end
    end

    always @(posedge clk_2x) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [15:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Strobe is driven after one edge and takes effect on the next
    task automatic write_reg(input io_reg_e reg_addr, input logic [15:0] data);
        @(posedge clk_2x);
        bus_req <= '{write: 1'b1, read: 1'b0, addr: reg_addr, wdata: data};
        @(posedge clk_2x);
        bus_req <= IDLE_REQ;
    endtask

    task automatic read_reg(input io_reg_e reg_addr, output logic [15:0] data);
        @(posedge clk_2x);
        bus_req <= '{write: 1'b0, read: 1'b1, addr: reg_addr, wdata: 16'h0000};
        @(posedge clk_2x);
        bus_req <= IDLE_REQ;
        @(negedge clk_2x);
        data = rdata;
    endtask

    task automatic wait_ym_idle();
        logic [15:0] raw;
        io_status_t status;
        do begin
            read_reg(REG_STATUS, raw);
            status = io_status_t'(raw);
        end while (status.ym_busy);
    endtask

    task automatic check_ym_fields(input ym_word_t expected, input ym_word_t actual);
        check_value("ym data", 16'(expected.data), 16'(actual.data));
        check_value("ym a0", 16'(expected.a0), 16'(actual.a0));
        check_value("ym cs_n", 16'(expected.cs_n), 16'(actual.cs_n));
        check_value("ym wr_n", 16'(expected.wr_n), 16'(actual.wr_n));
        check_value("ym ic_n", 16'(expected.ic_n), 16'(actual.ic_n));
        check_value("ym volume_up_down", 16'(expected.volume_up_down),
                    16'(actual.volume_up_down));
        check_value("ym volume_clk", 16'(expected.volume_clk), 16'(actual.volume_clk));
    endtask

    task automatic reset_values();
        logic [15:0] raw;
        @(negedge clk_2x);
        check_value("reset led", 16'h0000, {8'h00, led});
        check_value("reset pad_latch", 16'h0000, 16'(pad_latch));
        check_value("reset pad_clk", 16'h0001, 16'(pad_clk));
        check_value("reset shift_load", 16'h0000, 16'(ym_pmod_shift_load));
        check_value("reset rdata", 16'h0000, rdata);
        read_reg(REG_STATUS, raw);
        check_value("reset status", 16'h0000, raw);
    endtask

    // The master clock toggles every IO_YM_CLK_DIV cycles
    task automatic ym_clock_period();
        logic start_level;
        logic expected;
        int k;
        @(negedge clk_2x);
        start_level = ym_pmod_clk;
        // Align to a toggle so each half period is seen in full
        while (ym_pmod_clk === start_level) begin
            @(negedge clk_2x);
        end
        start_level = ym_pmod_clk;
        for (k = 1; k <= 4 * `IO_YM_CLK_DIV; k++) begin
            @(negedge clk_2x);
            expected = ((k / `IO_YM_CLK_DIV) % 2 == 0) ? start_level : ~start_level;
            check_value("ym_pmod_clk", 16'(expected), 16'(ym_pmod_clk));
        end
    endtask

    task automatic led_writes();
        logic [15:0] raw;
        logic [7:0] value;
        int i;
        for (i = 0; i < 10; i++) begin
            raw = next_random();
            value = raw[7:0];
            write_reg(REG_LED, {8'h00, value});
            @(negedge clk_2x);
            check_value("led output", {8'h00, value}, {8'h00, led});
            read_reg(REG_LED, raw);
            check_value("led readback", {8'h00, value}, raw);
        end
    endtask

    task automatic gamepad_rounds();
        logic [15:0] raw;
        logic [7:0] seq_start;
        io_status_t status;
        int round;
        for (round = 0; round < 5; round++) begin
            raw = next_random();
            @(posedge clk_2x);
            buttons1 <= pad_buttons_t'(raw[11:0]);
            raw = next_random();
            buttons2 <= pad_buttons_t'(raw[11:0]);
            read_reg(REG_STATUS, raw);
            status = io_status_t'(raw);
            seq_start = status.pad_seq;
            // Second scan is the first one sure to latch the new buttons
            while (8'(status.pad_seq - seq_start) < 8'd2) begin
                read_reg(REG_STATUS, raw);
                status = io_status_t'(raw);
            end
            read_reg(REG_PAD1, raw);
            check_value("pad1 buttons", {4'h0, buttons1}, raw);
            read_reg(REG_PAD2, raw);
            check_value("pad2 buttons", {4'h0, buttons2}, raw);
        end
    endtask

    task automatic ym_words();
        logic [15:0] raw;
        ym_word_t expected;
        int count_start;
        int i;
        count_start = ym_count;
        for (i = 0; i < YM_WORDS; i++) begin
            raw = next_random();
            expected = ym_word_t'(raw[`IO_YM_WORD_BITS-1:0]);
            wait_ym_idle();
            write_reg(REG_YM, raw);
            wait_ym_idle();
            check_ym_fields(expected, ym_last);
        end
        check_value("ym word count", 16'(YM_WORDS), 16'(ym_count - count_start));
    endtask

    task automatic ym_backpressure();
        logic [15:0] first;
        logic [15:0] second;
        logic [15:0] raw;
        io_status_t status;
        int count_start;
        first = next_random();
        second = next_random();
        wait_ym_idle();
        count_start = ym_count;
        // Second write lands while the first start is still pending
        @(posedge clk_2x);
        bus_req <= '{write: 1'b1, read: 1'b0, addr: REG_YM, wdata: first};
        @(posedge clk_2x);
        bus_req <= '{write: 1'b1, read: 1'b0, addr: REG_YM, wdata: second};
        @(posedge clk_2x);
        bus_req <= IDLE_REQ;
        wait_ym_idle();
        check_value("overrun word count", 16'h0001, 16'(ym_count - count_start));
        check_value("overrun captured word", {2'b00, first[13:0]}, {2'b00, ym_last});
        read_reg(REG_STATUS, raw);
        status = io_status_t'(raw);
        check_value("overrun set", 16'h0001, 16'(status.overrun));
        write_reg(REG_STATUS, 16'h0000);
        read_reg(REG_STATUS, raw);
        status = io_status_t'(raw);
        check_value("overrun cleared", 16'h0000, 16'(status.overrun));
    endtask

    initial begin
        rng_state = 32'd30;
        arst_n = 1'b0;
        bus_req = IDLE_REQ;
        buttons1 = '0;
        buttons2 = '0;
        repeat (3) @(posedge clk_2x);
        arst_n <= 1'b1;

        reset_values();
        ym_clock_period();
        led_writes();
        gamepad_rounds();
        ym_words();
        ym_backpressure();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* io_subsystem.f */
+incdir+.
io_pkg.sv
gamepad_reader.sv
ym_pmod_shifter.sv
io_regs.sv
io_subsystem.sv
mock_gamepad.sv
io_subsystem_tb.sv

/* Makefile */
TOP := io_subsystem_tb

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f io_subsystem.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only -Wall --timing --top-module io_subsystem -f io_subsystem.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
